// File: rtsim_input.txt
# W addr data | S drive piezo iq_mode(0 low, 1 high, 2 random) cycles
# E field forward reflect clips tol (tol in ADC LSBs on field and reflect)
# Reset state, every gain zero
S 1000 1000 2 100
E 0 0 0 0 0
# Drive gain 0.5, forward gain 0.75, field shift at default 3
W 0 16384
W 1 24576
S 65536 0 2 1400
E 8192 12288 4096 0 3
# Beam on every mode cycle, charge 1024 pulls field down by 8 x charge
W 6 1
W 7 1024
S 65536 0 1 1400
E 6144 12288 6144 0 3
# Beam off, piezo near full scale plus Lorentz term overflows the sum
W 6 0
W 3 131071
W 4 32768
S 65536 131071 1 1400
E 8192 12288 4096 2 3
# Piezo and Lorentz off again
W 4 0
S 65536 0 1 100
E 8192 12288 4096 0 3
# Large mode gains with mech shift 0 saturate the mode states
W 8 0
W 16 131071
W 17 131071
S 65536 131071 1 200
E 8192 12288 4096 1 3
# Mode 0 gain 0.5, detune 0.5, mech_x 32768 moves the target to 16384
W 3 32768
W 16 16384
W 17 0
W 5 16384
S 65536 65536 1 1400
E 4096 12288 8192 0 3

// File: compile.f
+incdir+.
rtsim_bus_pkg.sv
rtsim_sig_pkg.sv
pipe_delay.sv
rtsim_config.sv
rtsim_sequencer.sv
cav_station.sv
mech_mode_bank.sv
drive_combiner.sv
rtsim.sv
rtsim_tb.sv

// File: rtsim_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rtsim_tb
  import rtsim_bus_pkg::*, rtsim_sig_pkg::*;
();

  // One line of the stimulus file, fields used per kind
  typedef struct packed {
    logic [7:0] kind;
    int         a;
    int         b;
    int         c;
    int         d;
    int         e;
  } op_t;

  logic       clk;
  logic       rst;
  logic       iq;
  sample_t    drive;
  sample_t    piezo;
  lb_write_t  lb;
  adc_set_t   adc;
  logic [7:0] clips;

  op_t        ops [$];
  int         total_cycles;
  logic       loaded;
  logic       file_ok;
  int         adc_errs;
  int         clip_errs;

  rtsim uut (
    .clk   (clk),
    .rst   (rst),
    .iq    (iq),
    .drive (drive),
    .piezo (piezo),
    .lb    (lb),
    .adc   (adc),
    .clips (clips)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Whole file first, step cycles summed for the watchdog
  task automatic load_ops(output logic ok);
    int         fd;
    int         n;
    string      line;
    logic [7:0] kind;
    int         a;
    int         b;
    int         c;
    int         d;
    int         e;
    op_t        op;
    ok = 1'b0;
    total_cycles = 0;
    fd = $fopen("rtsim_input.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        kind = 8'h00;
        a = 0;
        b = 0;
        c = 0;
        d = 0;
        e = 0;
        n = $fgets(line, fd);
        if (n > 0) n = $sscanf(line, "%c %d %d %d %d %d", kind, a, b, c, d, e);
        // Comment and blank lines fall through here
        if (kind == "W" || kind == "S" || kind == "E") begin
          op.kind = kind;
          op.a = a;
          op.b = b;
          op.c = c;
          op.d = d;
          op.e = e;
          ops.push_back(op);
          if (kind == "S") total_cycles += d;
        end
      end
      $fclose(fd);
      ok = (ops.size() > 0);
    end
  endtask

  // Single-cycle write strobe, register loads on the next rising edge
  task automatic bus_write(input int addr, input int data);
    lb = '{addr: 15'(addr), data: 32'(data), we: 1'b1};
    @(negedge clk);
    lb.we = 1'b0;
  endtask

  // iq mode 0 low, 1 high, 2 random per cycle
  task automatic hold_inputs(input int drv, input int pz, input int iq_mode, input int cycles);
    int unsigned r;
    repeat (cycles) begin
      drive = sample_t'(drv);
      piezo = sample_t'(pz);
      if (iq_mode == 2) begin
        r = $urandom;
        iq = r[0];
      end else begin
        iq = (iq_mode != 0);
      end
      @(negedge clk);
    end
  endtask

  function automatic logic within_tol(input adc_t got, input adc_t want, input int tol);
    int diff;
    diff = int'(got) - int'(want);
    if (diff < 0) diff = -diff;
    return diff <= tol;
  endfunction

  // Forward is exact, field and reflect settle within tol
  task automatic check_adc(input adc_set_t got, input adc_set_t want, input int tol);
    if ($isunknown(got)) begin
      $display("mismatch at %0t: adc has unknown bits", $time);
      adc_errs++;
    end else begin
      if (!within_tol(got.field, want.field, tol)) begin
        $display("mismatch at %0t: adc.field got %0d expected %0d tol %0d",
                 $time, got.field, want.field, tol);
        adc_errs++;
      end
      if (got.forward !== want.forward) begin
        $display("mismatch at %0t: adc.forward got %0d expected %0d",
                 $time, got.forward, want.forward);
        adc_errs++;
      end
      if (!within_tol(got.reflect, want.reflect, tol)) begin
        $display("mismatch at %0t: adc.reflect got %0d expected %0d tol %0d",
                 $time, got.reflect, want.reflect, tol);
        adc_errs++;
      end
    end
  endtask

  task automatic check_clips(input clip_t got, input clip_t want);
    if (got !== want) begin
      $display("mismatch at %0t: clips edrive/res got %b%b expected %b%b", $time,
               got.edrive_clip, got.res_clip, want.edrive_clip, want.res_clip);
      clip_errs++;
    end
  endtask

  task automatic run_ops();
    op_t      op;
    adc_set_t want_adc;
    clip_t    want_clip;
    foreach (ops[i]) begin
      op = ops[i];
      case (op.kind)
        "W": bus_write(op.a, op.b);
        "S": hold_inputs(op.a, op.b, op.c, op.d);
        "E": begin
          want_adc = '{field: adc_t'(op.a), forward: adc_t'(op.b), reflect: adc_t'(op.c)};
          want_clip.edrive_clip = op.d[1];
          want_clip.res_clip = op.d[0];
          check_adc(adc, want_adc, op.e);
          check_clips(clip_t'(clips[1:0]), want_clip);
          // Spare status bits above the two flags read zero
          if (clips[7:2] !== 6'b0) begin
            $display("mismatch at %0t: clips spare bits got %b expected 000000",
                     $time, clips[7:2]);
            clip_errs++;
          end
        end
        default: ;
      endcase
    end
  endtask

  initial begin
    void'($urandom(32'hfcd6));
    rst = 1'b1;
    iq = 1'b0;
    drive = '0;
    piezo = '0;
    lb = '0;
    loaded = 1'b0;
    adc_errs = 0;
    clip_errs = 0;
    load_ops(file_ok);
    if (!file_ok) begin
      $display("could not read any stimulus from rtsim_input.txt");
      $display("=== FAIL ===");
    end else begin
      loaded = 1'b1;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      run_ops();
      $display("adc errors: %0d, clip errors: %0d", adc_errs, clip_errs);
      if (adc_errs == 0 && clip_errs == 0) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
    end
    $finish;
  end

  // Margin covers reset and the bus write cycles
  initial begin
    wait (loaded);
    #((total_cycles + 200) * 10);
    $display("timeout: run did not complete within %0d cycles", total_cycles + 200);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtsim.sv
`timescale 1ns/1ps
`default_nettype none

module rtsim
  import rtsim_bus_pkg::*, rtsim_sig_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       iq,
  input  sample_t    drive,
  input  sample_t    piezo,
  input  lb_write_t  lb,
  output adc_set_t   adc,
  output logic [7:0] clips
);

  rtsim_cfg_t cfg;
  logic       start_outer;
  logic       start_eig;
  logic       beam_pulse;
  sample_t    mech_x;
  sample_t    cav_eig_drive;
  sample_t    piezo_eig_drive;
  sample_t    eig_drive;
  logic       res_clip;
  adc_set_t   adc_raw;
  clip_t      clip;

  rtsim_config u_config (
    .clk (clk),
    .rst (rst),
    .lb  (lb),
    .cfg (cfg)
  );

  // Raw start strobe stays inside the sequencer
  rtsim_sequencer u_sequencer (
    .clk         (clk),
    .rst         (rst),
    .iq          (iq),
    .beam_period (cfg.beam_period),
    .start       (),
    .start_outer (start_outer),
    .start_eig   (start_eig),
    .beam_pulse  (beam_pulse)
  );

  cav_station u_station (
    .clk             (clk),
    .rst             (rst),
    .cfg             (cfg),
    .start_outer     (start_outer),
    .beam_pulse      (beam_pulse),
    .drive           (drive),
    .piezo           (piezo),
    .mech_x          (mech_x),
    .adc             (adc_raw),
    .cav_eig_drive   (cav_eig_drive),
    .piezo_eig_drive (piezo_eig_drive)
  );

  // Eigenmode drive closes the loop into the mechanical bank
  drive_combiner u_combiner (
    .clk             (clk),
    .rst             (rst),
    .cav_eig_drive   (cav_eig_drive),
    .piezo_eig_drive (piezo_eig_drive),
    .res_clip        (res_clip),
    .eig_drive       (eig_drive),
    .clip            (clip)
  );

  mech_mode_bank u_mech (
    .clk       (clk),
    .rst       (rst),
    .cfg       (cfg),
    .start_eig (start_eig),
    .eig_drive (eig_drive),
    .mech_x    (mech_x),
    .res_clip  (res_clip)
  );

  // ADC levels appear 3 cycles after start_outer
  pipe_delay #(.T(adc_set_t), .LEN(2)) u_adc_dly (
    .clk  (clk),
    .rst  (rst),
    .din  (adc_raw),
    .dout (adc)
  );

  assign clips = {6'b0, clip};

endmodule

`default_nettype wire

// File: drive_combiner.sv
`timescale 1ns/1ps
`default_nettype none

`include "rtsim_settings.svh"

module drive_combiner
  import rtsim_sig_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  sample_t cav_eig_drive,
  input  sample_t piezo_eig_drive,
  input  logic    res_clip,
  output sample_t eig_drive,
  output clip_t   clip
);

  // One guard bit is enough for the sum of two words
  logic signed [`RTSIM_SAMPLE_W:0] sum_q;
  logic                            edrive_clip_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      sum_q         <= '0;
      eig_drive     <= '0;
      edrive_clip_q <= 1'b0;
    end else begin
      // Stage 1, widen and add
      sum_q         <= cav_eig_drive + piezo_eig_drive;
      // Stage 2, clamp and flag the same sample
      eig_drive     <= sat_sample(wide_t'(sum_q));
      edrive_clip_q <= sat_over(wide_t'(sum_q));
    end
  end

  // Not latched, caller handles sticky status
  assign clip = '{edrive_clip: edrive_clip_q, res_clip: res_clip};

endmodule

`default_nettype wire

// File: mech_mode_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "rtsim_settings.svh"

module mech_mode_bank
  import rtsim_bus_pkg::*, rtsim_sig_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  rtsim_cfg_t cfg,
  input  logic       start_eig,
  input  sample_t    eig_drive,
  output sample_t    mech_x,
  output logic       res_clip
);

  localparam int N        = `RTSIM_N_MECH_MODES;
  localparam int N_CYCLES = 2 * N;
  localparam int PH_W     = $clog2(N_CYCLES);
  localparam int IDX_W    = PH_W - 1;
  localparam int FRAC     = `RTSIM_GAIN_FRAC;

  logic [PH_W-1:0]  phase_q;
  logic [PH_W-1:0]  phase;
  logic [IDX_W-1:0] idx;
  logic             odd;
  logic             first;
  logic             last;
  sample_t          mode_st [N];
  sample_t          st_q;
  wide_t            tgt_q;
  wide_t            prod_w;
  wide_t            upd_w;
  sample_t          upd;
  logic             upd_ovf;
  wide_t            acc_q;
  wide_t            sum_w;
  logic             clip_acc_q;
  logic             clip_now;

  // start_eig is phase zero, mode m owns phases 2m and 2m+1
  assign phase = start_eig ? '0 : phase_q;
  assign idx   = phase[PH_W-1:1];
  assign odd   = phase[0];
  assign first = (idx == '0);
  assign last  = (idx == IDX_W'(N - 1));

  always_ff @(posedge clk) begin
    if (rst) phase_q <= '0;
    else phase_q <= (phase == PH_W'(N_CYCLES - 1)) ? '0 : phase + 1'b1;
  end

  // Even phase, per-mode excitation, kept wide so overdrive shows up
  assign prod_w = (wide_t'(eig_drive) * wide_t'($signed(cfg.mode_gain[idx]))) >>> FRAC;

  // Odd phase, leaky step toward the excitation
  assign upd_w   = wide_t'(st_q) + ((tgt_q - wide_t'(st_q)) >>> cfg.mech_shift);
  assign upd     = sat_sample(upd_w);
  assign upd_ovf = sat_over(upd_w);

  // Running sum and clip flag restart at mode 0
  assign sum_w    = (first ? '0 : acc_q) + wide_t'(upd);
  assign clip_now = (first ? 1'b0 : clip_acc_q) | upd_ovf;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int m = 0; m < N; m++) begin
        mode_st[m] <= '0;
      end
      st_q       <= '0;
      tgt_q      <= '0;
      acc_q      <= '0;
      clip_acc_q <= 1'b0;
      mech_x     <= '0;
      res_clip   <= 1'b0;
    end else if (!odd) begin
      // Fetch the state and the excitation
      st_q  <= mode_st[idx];
      tgt_q <= prod_w;
    end else begin
      // Write back and accumulate
      mode_st[idx] <= upd;
      acc_q        <= sum_w;
      clip_acc_q   <= clip_now;
      // Displacement and clip status hold for one full period
      if (last) begin
        mech_x   <= sat_sample(sum_w);
        res_clip <= clip_now;
      end
    end
  end

endmodule

`default_nettype wire

// File: cav_station.sv
`timescale 1ns/1ps
`default_nettype none

`include "rtsim_settings.svh"

module cav_station
  import rtsim_bus_pkg::*, rtsim_sig_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  rtsim_cfg_t cfg,
  input  logic       start_outer,
  input  logic       beam_pulse,
  input  sample_t    drive,
  input  sample_t    piezo,
  input  sample_t    mech_x,
  output adc_set_t   adc,
  output sample_t    cav_eig_drive,
  output sample_t    piezo_eig_drive
);

  localparam int FRAC = `RTSIM_GAIN_FRAC;
  // Square of a full-scale field lands back at full scale
  localparam int SQ_SHIFT = `RTSIM_SAMPLE_W - 1;

  sample_t field_q;
  sample_t fwd_q;
  wide_t   drive_w;
  wide_t   detune_w;
  wide_t   beam_w;
  wide_t   target_w;
  wide_t   field_nxt_w;
  wide_t   fwd_w;
  wide_t   refl_w;
  wide_t   fsq_w;
  wide_t   lorentz_w;
  wide_t   piezo_w;

  // Drive target, pulled off resonance by the mechanical displacement
  assign drive_w  = (wide_t'(drive) * wide_t'($signed(cfg.drive_gain))) >>> FRAC;
  assign detune_w = (wide_t'(mech_x) * wide_t'($signed(cfg.detune_gain))) >>> FRAC;
  assign target_w = drive_w - detune_w;

  // Charge removed by one beam bunch
  assign beam_w = beam_pulse ? wide_t'($signed(cfg.beam_charge)) : '0;

  // First-order low-pass toward the target
  assign field_nxt_w = wide_t'(field_q)
                     + ((target_w - wide_t'(field_q)) >>> cfg.field_shift)
                     - beam_w;

  // Forward wave follows the drive directly
  assign fwd_w = (wide_t'(drive) * wide_t'($signed(cfg.fwd_gain))) >>> FRAC;

  // Piezo term for the eigenmode drive
  assign piezo_w = (wide_t'(piezo) * wide_t'($signed(cfg.piezo_gain))) >>> FRAC;

  always_ff @(posedge clk) begin
    if (rst) begin
      field_q         <= '0;
      fwd_q           <= '0;
      piezo_eig_drive <= '0;
    end else begin
      piezo_eig_drive <= sat_sample(piezo_w);
      // Field and forward move together, once per mode cycle
      if (start_outer) begin
        field_q <= sat_sample(field_nxt_w);
        fwd_q   <= sat_sample(fwd_w);
      end
    end
  end

  // Reflected wave is what the cavity does not absorb
  assign refl_w = wide_t'(fwd_q) - wide_t'(field_q);

  assign adc = '{
    field:   to_adc(field_q),
    forward: to_adc(fwd_q),
    reflect: to_adc(sat_sample(refl_w))
  };

  // Lorentz force scales with stored energy, field squared
  assign fsq_w     = (wide_t'(field_q) * wide_t'(field_q)) >>> SQ_SHIFT;
  assign lorentz_w = (fsq_w * wide_t'($signed(cfg.lorentz_gain))) >>> FRAC;

  assign cav_eig_drive = sat_sample(lorentz_w);

endmodule

`default_nettype wire

// File: rtsim_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rtsim_settings.svh"

module rtsim_sequencer (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            iq,
  input  logic [`RTSIM_BEAM_PERIOD_W-1:0] beam_period,
  output logic                            start,
  output logic                            start_outer,
  output logic                            start_eig,
  output logic                            beam_pulse
);

  // One full pass over the mechanical bank
  localparam int N_CYCLES = 2 * `RTSIM_N_MECH_MODES;
  localparam int CNT_W = $clog2(N_CYCLES);

  logic [CNT_W-1:0]                cycle_cnt;
  logic [`RTSIM_BEAM_PERIOD_W-1:0] beam_cnt;
  logic                            beam_adv;
  logic                            beam_hit;

  // Down-counter, start fires on the cycle after it hits zero
  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_cnt <= CNT_W'(N_CYCLES - 1);
      start     <= 1'b0;
    end else begin
      start     <= (cycle_cnt == '0);
      cycle_cnt <= (cycle_cnt == '0) ? CNT_W'(N_CYCLES - 1) : cycle_cnt - 1'b1;
    end
  end

  // Staggered copies for the station and the mechanical bank
  pipe_delay #(.T(logic), .LEN(1)) start_outer_dly (
    .clk  (clk),
    .rst  (rst),
    .din  (start),
    .dout (start_outer)
  );

  pipe_delay #(.T(logic), .LEN(2)) start_eig_dly (
    .clk  (clk),
    .rst  (rst),
    .din  (start),
    .dout (start_eig)
  );

  // Beam counter only moves on gated mode cycles
  // A zero period keeps the beam off
  assign beam_adv = start_outer & iq & (beam_period != '0);
  assign beam_hit = (beam_cnt >= beam_period - 1'b1);

  // Pulse lines up with start_outer itself
  assign beam_pulse = beam_adv & beam_hit;

  always_ff @(posedge clk) begin
    if (rst) begin
      beam_cnt <= '0;
    end else if (beam_period == '0) begin
      beam_cnt <= '0;
    end else if (beam_adv) begin
      beam_cnt <= beam_hit ? '0 : beam_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rtsim_config.sv
`timescale 1ns/1ps
`default_nettype none

`include "rtsim_settings.svh"

module rtsim_config
  import rtsim_bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  lb_write_t  lb,
  output rtsim_cfg_t cfg
);

  always_ff @(posedge clk) begin
    if (rst) begin
      // Gains off, shifts at their defaults
      cfg             <= '0;
      cfg.field_shift <= shift_t'(`RTSIM_FIELD_SHIFT_DEF);
      cfg.mech_shift  <= shift_t'(`RTSIM_MECH_SHIFT_DEF);
    end else if (lb.we) begin
      // Each field keeps only the low bits of the data word
      case (lb.addr)
        REG_DRIVE_GAIN:   cfg.drive_gain   <= lb.data[`RTSIM_GAIN_W-1:0];
        REG_FWD_GAIN:     cfg.fwd_gain     <= lb.data[`RTSIM_GAIN_W-1:0];
        REG_FIELD_SHIFT:  cfg.field_shift  <= lb.data[`RTSIM_SHIFT_W-1:0];
        REG_PIEZO_GAIN:   cfg.piezo_gain   <= lb.data[`RTSIM_GAIN_W-1:0];
        REG_LORENTZ_GAIN: cfg.lorentz_gain <= lb.data[`RTSIM_GAIN_W-1:0];
        REG_DETUNE_GAIN:  cfg.detune_gain  <= lb.data[`RTSIM_GAIN_W-1:0];
        REG_BEAM_PERIOD:  cfg.beam_period  <= lb.data[`RTSIM_BEAM_PERIOD_W-1:0];
        REG_BEAM_CHARGE:  cfg.beam_charge  <= lb.data[`RTSIM_GAIN_W-1:0];
        REG_MECH_SHIFT:   cfg.mech_shift   <= lb.data[`RTSIM_SHIFT_W-1:0];
        // Unknown or mode gain addresses, handled below
        default: ;
      endcase
      // Mode gains sit in a contiguous block
      for (int m = 0; m < `RTSIM_N_MECH_MODES; m++) begin
        if (lb.addr == REG_MODE_GAIN_BASE + 15'(m)) begin
          cfg.mode_gain[m] <= lb.data[`RTSIM_GAIN_W-1:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: pipe_delay.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_delay #(
  parameter type T   = logic,
  parameter int  LEN = 1
) (
  input  logic clk,
  input  logic rst,
  input  T     din,
  output T     dout
);

  // Stage 0 takes the input, the last stage drives the output
  T stage [LEN];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < LEN; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= din;
      for (int i = 1; i < LEN; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign dout = stage[LEN-1];

endmodule

`default_nettype wire

// File: rtsim_sig_pkg.sv
`default_nettype none

`include "rtsim_settings.svh"

package rtsim_sig_pkg;

  typedef logic signed [`RTSIM_SAMPLE_W-1:0] sample_t;
  typedef logic signed [`RTSIM_ADC_W-1:0] adc_t;

  // Baseband ADC levels
  typedef struct packed {
    adc_t field;
    adc_t forward;
    adc_t reflect;
  } adc_set_t;

  // Clip flags, edrive above res as on the status byte
  typedef struct packed {
    logic edrive_clip;
    logic res_clip;
  } clip_t;

  // Wide intermediate for products and sums before saturation
  typedef logic signed [39:0] wide_t;

  localparam wide_t SAMPLE_MAX = wide_t'(2 ** (`RTSIM_SAMPLE_W - 1) - 1);
  localparam wide_t SAMPLE_MIN = -wide_t'(2 ** (`RTSIM_SAMPLE_W - 1));

  // Clamp a wide value into the datapath word
  function automatic sample_t sat_sample(input wide_t x);
    sample_t s;
    if (x > SAMPLE_MAX) s = SAMPLE_MAX[`RTSIM_SAMPLE_W-1:0];
    else if (x < SAMPLE_MIN) s = SAMPLE_MIN[`RTSIM_SAMPLE_W-1:0];
    else s = x[`RTSIM_SAMPLE_W-1:0];
    return s;
  endfunction

  // High when the clamp above would change the value
  function automatic logic sat_over(input wide_t x);
    return (x > SAMPLE_MAX) || (x < SAMPLE_MIN);
  endfunction

  // Drop the low bits to get the ADC level
  function automatic adc_t to_adc(input sample_t x);
    sample_t y;
    y = x >>> (`RTSIM_SAMPLE_W - `RTSIM_ADC_W);
    return y[`RTSIM_ADC_W-1:0];
  endfunction

endpackage

`default_nettype wire

// File: rtsim_bus_pkg.sv
`default_nettype none

`include "rtsim_settings.svh"

package rtsim_bus_pkg;

  // One local-bus write, strobe valid for a single cycle
  typedef struct packed {
    logic [14:0] addr;
    logic [31:0] data;
    logic        we;
  } lb_write_t;

  // Register map
  localparam logic [14:0] REG_DRIVE_GAIN     = 15'd0;
  localparam logic [14:0] REG_FWD_GAIN       = 15'd1;
  localparam logic [14:0] REG_FIELD_SHIFT    = 15'd2;
  localparam logic [14:0] REG_PIEZO_GAIN     = 15'd3;
  localparam logic [14:0] REG_LORENTZ_GAIN   = 15'd4;
  localparam logic [14:0] REG_DETUNE_GAIN    = 15'd5;
  localparam logic [14:0] REG_BEAM_PERIOD    = 15'd6;
  localparam logic [14:0] REG_BEAM_CHARGE    = 15'd7;
  localparam logic [14:0] REG_MECH_SHIFT     = 15'd8;
  // First of the per-mode gains, one address per mode
  localparam logic [14:0] REG_MODE_GAIN_BASE = 15'd16;

  typedef logic signed [`RTSIM_GAIN_W-1:0] gain_t;
  typedef logic [`RTSIM_SHIFT_W-1:0] shift_t;

  // Full coefficient set seen by the datapath
  typedef struct packed {
    gain_t                                 drive_gain;
    gain_t                                 fwd_gain;
    shift_t                                field_shift;
    gain_t                                 piezo_gain;
    gain_t                                 lorentz_gain;
    gain_t                                 detune_gain;
    logic [`RTSIM_BEAM_PERIOD_W-1:0]       beam_period;
    gain_t                                 beam_charge;
    shift_t                                mech_shift;
    gain_t [`RTSIM_N_MECH_MODES-1:0]       mode_gain;
  } rtsim_cfg_t;

endpackage

`default_nettype wire

// File: rtsim_settings.svh
`ifndef RTSIM_SETTINGS_SVH
`define RTSIM_SETTINGS_SVH

// Mechanical modes in the bank, two clock cycles each
`define RTSIM_N_MECH_MODES 7

// Datapath, ADC and coefficient word widths
`define RTSIM_SAMPLE_W 18
`define RTSIM_ADC_W 16
`define RTSIM_GAIN_W 18

// Gains are signed fractions with this many bits below the point
`define RTSIM_GAIN_FRAC 15

// Shift registers and beam period register widths
`define RTSIM_SHIFT_W 5
`define RTSIM_BEAM_PERIOD_W 12

// Reset values of the two time-constant shifts
`define RTSIM_FIELD_SHIFT_DEF 3
`define RTSIM_MECH_SHIFT_DEF 2

`endif
